/* wired_cfg_pkg.sv */
package wired_cfg_pkg;

  // register value width
  localparam int unsigned DATA_W = 32;

  // architectural register number width
  localparam int unsigned ARCH_W = 5;

  // number of architectural registers
  localparam int unsigned NREG = 1 << ARCH_W;

  // widest ROB id; ROB_DEPTH uses its low bits
  localparam int unsigned ROB_ID_W_MAX = 4;

  typedef logic [DATA_W-1:0] data_t;

  typedef logic [ARCH_W-1:0] arch_rid_t;

  typedef logic [ROB_ID_W_MAX-1:0] rob_rid_t;

endpackage

/* wired_pipe_pkg.sv */
package wired_pipe_pkg;

  localparam int unsigned IMM_W = 16;

  typedef logic [2:0] alu_op_t;

  // alu opcodes
  localparam alu_op_t OP_ADD = 3'd0;
  localparam alu_op_t OP_SUB = 3'd1;
  localparam alu_op_t OP_AND = 3'd2;
  localparam alu_op_t OP_OR  = 3'd3;
  localparam alu_op_t OP_XOR = 3'd4;
  localparam alu_op_t OP_LI  = 3'd5;

  // decoded instruction from the front end
  typedef struct packed {
    alu_op_t                  op;
    wired_cfg_pkg::arch_rid_t rd;
    wired_cfg_pkg::arch_rid_t rs1;
    wired_cfg_pkg::arch_rid_t rs2;
    logic [IMM_W-1:0]         imm;
  } inst_pack_t;

  // renamed instruction waiting in the dispatch register
  typedef struct packed {
    alu_op_t                        op;
    logic [IMM_W-1:0]               imm;
    wired_cfg_pkg::arch_rid_t       rd;
    wired_cfg_pkg::rob_rid_t        dst_id;
    logic [1:0]                     src_rdy;
    wired_cfg_pkg::rob_rid_t [1:0]  src_id;
    wired_cfg_pkg::data_t [1:0]     src_val;
  } dispatch_t;

  // one lane of the common data bus
  typedef struct packed {
    logic                    valid;
    wired_cfg_pkg::rob_rid_t id;
    wired_cfg_pkg::data_t    data;
  } cdb_t;

  typedef struct packed {
    logic                     valid;
    wired_cfg_pkg::arch_rid_t rd;
    wired_cfg_pkg::data_t     data;
  } retire_t;

endpackage

/* wired_arf.sv */
`timescale 1ns/100ps

module wired_arf (
  input  logic                          clk,
  input  logic                          rst_n,
  input  wired_cfg_pkg::arch_rid_t [3:0] raddr_i,
  output wired_cfg_pkg::data_t [3:0]     rdata_o,
  input  logic [1:0]                    we_i,
  input  wired_cfg_pkg::arch_rid_t [1:0] waddr_i,
  input  wired_cfg_pkg::data_t [1:0]     wdata_i
);
  import wired_cfg_pkg::*;

  data_t regs_q [NREG];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 0; r < NREG; r++) begin
        regs_q[r] <= '0;
      end
    end else begin
      // slot 1 is younger and wins on the same register
      for (int w = 0; w < 2; w++) begin
        if (we_i[w] && waddr_i[w] != '0) begin
          regs_q[waddr_i[w]] <= wdata_i[w];
        end
      end
    end
  end

  // read with same-cycle write forwarding
  always_comb begin
    for (int k = 0; k < 4; k++) begin
      rdata_o[k] = regs_q[raddr_i[k]];
      for (int w = 0; w < 2; w++) begin
        if (we_i[w] && waddr_i[w] == raddr_i[k] && raddr_i[k] != '0) begin
          rdata_o[k] = wdata_i[w];
        end
      end
    end
  end

endmodule

/* wired_rename.sv */
`timescale 1ns/100ps

module wired_rename #(
  parameter int unsigned ROB_DEPTH = 8
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  wired_cfg_pkg::arch_rid_t [3:0] rs_i,
  input  logic [1:0]                     alloc_i,
  input  wired_cfg_pkg::arch_rid_t [1:0] rd_i,
  input  wired_cfg_pkg::rob_rid_t [1:0]  alloc_id_i,
  output logic [3:0]                     busy_o,
  output wired_cfg_pkg::rob_rid_t [3:0]  src_id_o,
  input  logic [1:0]                     retire_i,
  input  wired_cfg_pkg::arch_rid_t [1:0] retire_rd_i,
  input  wired_cfg_pkg::rob_rid_t [1:0]  retire_id_i
);
  import wired_cfg_pkg::*;

  localparam int unsigned IDX_W = $clog2(ROB_DEPTH);

  logic [NREG-1:0]  busy_q;
  logic [IDX_W-1:0] id_q [NREG];

  // sources 2 and 3 belong to slot 1 and see slot 0's rd
  always_comb begin
    for (int k = 0; k < 4; k++) begin
      busy_o[k]   = busy_q[rs_i[k]];
      src_id_o[k] = rob_rid_t'(id_q[rs_i[k]]);
      if (k >= 2 && alloc_i[0] && rd_i[0] == rs_i[k]) begin
        busy_o[k]   = 1'b1;
        src_id_o[k] = alloc_id_i[0];
      end
      if (rs_i[k] == '0) begin
        busy_o[k] = 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q <= '0;
    end else begin
      // only clear if no younger writer took the register
      for (int w = 0; w < 2; w++) begin
        if (retire_i[w] && busy_q[retire_rd_i[w]] &&
            id_q[retire_rd_i[w]] == retire_id_i[w][IDX_W-1:0]) begin
          busy_q[retire_rd_i[w]] <= 1'b0;
        end
      end
      // allocation overrides a retire in the same cycle
      for (int w = 0; w < 2; w++) begin
        if (alloc_i[w] && rd_i[w] != '0) begin
          busy_q[rd_i[w]] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int w = 0; w < 2; w++) begin
      if (alloc_i[w]) begin
        id_q[rd_i[w]] <= alloc_id_i[w][IDX_W-1:0];
      end
    end
  end

endmodule

/* wired_rob.sv */
`timescale 1ns/100ps

module wired_rob #(
  parameter int unsigned ROB_DEPTH = 8
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [1:0]                     alloc_i,
  input  wired_cfg_pkg::arch_rid_t [1:0] alloc_rd_i,
  output wired_cfg_pkg::rob_rid_t [1:0]  alloc_id_o,
  output logic [1:0]                     free_o,
  input  wired_pipe_pkg::cdb_t [1:0]     cdb_i,
  input  wired_cfg_pkg::rob_rid_t [3:0]  look_id_i,
  output logic [3:0]                     look_done_o,
  output wired_cfg_pkg::data_t [3:0]     look_data_o,
  output logic [1:0]                     arf_we_o,
  output wired_cfg_pkg::arch_rid_t [1:0] arf_waddr_o,
  output wired_cfg_pkg::data_t [1:0]     arf_wdata_o,
  output wired_cfg_pkg::rob_rid_t [1:0]  retire_id_o,
  output wired_pipe_pkg::retire_t [1:0]  retire_o
);
  import wired_cfg_pkg::*;
  import wired_pipe_pkg::*;

  localparam int unsigned IDX_W = $clog2(ROB_DEPTH);
  localparam logic [IDX_W:0] CNT_TOP = (IDX_W+1)'(ROB_DEPTH - 1);

  arch_rid_t rd_q [ROB_DEPTH];
  data_t     data_q [ROB_DEPTH];
  logic [ROB_DEPTH-1:0]  done_q;
  logic [IDX_W-1:0]      head_q;
  logic [IDX_W-1:0]      tail_q;
  logic [IDX_W-1:0]      tail1;
  logic [IDX_W:0]        count_q;
  logic [1:0][IDX_W-1:0] ret_idx;
  logic [1:0]            ret;
  logic [1:0]            n_alloc;
  logic [1:0]            n_ret;
  retire_t [1:0]         ret_rec;

  // slot 1 takes the next entry only if slot 0 allocates
  assign tail1         = tail_q + IDX_W'(alloc_i[0]);
  assign alloc_id_o[0] = rob_rid_t'(tail_q);
  assign alloc_id_o[1] = rob_rid_t'(tail1);
  assign free_o[0]     = count_q <= CNT_TOP;
  assign free_o[1]     = count_q < CNT_TOP;

  always_comb begin
    for (int k = 0; k < 4; k++) begin
      look_done_o[k] = done_q[look_id_i[k][IDX_W-1:0]];
      look_data_o[k] = data_q[look_id_i[k][IDX_W-1:0]];
    end
  end

  // in-order retire, slot 1 only behind slot 0
  assign ret_idx[0] = head_q;
  assign ret_idx[1] = head_q + IDX_W'(1);
  assign ret[0]     = count_q != '0 && done_q[ret_idx[0]];
  assign ret[1]     = ret[0] && count_q > (IDX_W+1)'(1) && done_q[ret_idx[1]];

  always_comb begin
    for (int s = 0; s < 2; s++) begin
      ret_rec[s].valid = ret[s];
      ret_rec[s].rd    = rd_q[ret_idx[s]];
      ret_rec[s].data  = data_q[ret_idx[s]];
      arf_waddr_o[s]   = ret_rec[s].rd;
      arf_wdata_o[s]   = ret_rec[s].data;
      retire_id_o[s]   = rob_rid_t'(ret_idx[s]);
    end
  end
  assign arf_we_o = ret;

  assign n_alloc = {1'b0, alloc_i[0]} + {1'b0, alloc_i[1]};
  assign n_ret   = {1'b0, ret[0]} + {1'b0, ret[1]};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      done_q  <= '0;
    end else begin
      head_q  <= head_q + IDX_W'(n_ret);
      tail_q  <= tail_q + IDX_W'(n_alloc);
      count_q <= count_q + (IDX_W+1)'(n_alloc) - (IDX_W+1)'(n_ret);
      // a freed entry comes back not done
      for (int s = 0; s < 2; s++) begin
        if (ret[s]) begin
          done_q[ret_idx[s]] <= 1'b0;
        end
      end
      for (int l = 0; l < 2; l++) begin
        if (cdb_i[l].valid) begin
          done_q[cdb_i[l].id[IDX_W-1:0]] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_i[0]) begin
      rd_q[tail_q] <= alloc_rd_i[0];
    end
    if (alloc_i[1]) begin
      rd_q[tail1] <= alloc_rd_i[1];
    end
    for (int l = 0; l < 2; l++) begin
      if (cdb_i[l].valid) begin
        data_q[cdb_i[l].id[IDX_W-1:0]] <= cdb_i[l].data;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      retire_o <= '0;
    end else begin
      retire_o <= ret_rec;
    end
  end

endmodule

/* wired_alu.sv */
`timescale 1ns/100ps

module wired_alu (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [1:0]                      issue_i,
  input  wired_pipe_pkg::dispatch_t [1:0] op_i,
  output wired_pipe_pkg::cdb_t [1:0]      cdb_o
);
  import wired_cfg_pkg::*;
  import wired_pipe_pkg::*;

  data_t [1:0]    result;
  logic [1:0]     valid_q;
  rob_rid_t [1:0] id_q;
  data_t [1:0]    data_q;

  for (genvar i = 0; i < 2; i++) begin : g_lane
    always_comb begin
      case (op_i[i].op)
        OP_ADD:  result[i] = op_i[i].src_val[0] + op_i[i].src_val[1];
        OP_SUB:  result[i] = op_i[i].src_val[0] - op_i[i].src_val[1];
        OP_AND:  result[i] = op_i[i].src_val[0] & op_i[i].src_val[1];
        OP_OR:   result[i] = op_i[i].src_val[0] | op_i[i].src_val[1];
        OP_XOR:  result[i] = op_i[i].src_val[0] ^ op_i[i].src_val[1];
        OP_LI:   result[i] = {{(DATA_W - IMM_W){op_i[i].imm[IMM_W-1]}}, op_i[i].imm};
        default: result[i] = '0;
      endcase
      // x0 results retire as zero
      if (op_i[i].rd == '0) begin
        result[i] = '0;
      end
    end

    assign cdb_o[i].valid = valid_q[i];
    assign cdb_o[i].id    = id_q[i];
    assign cdb_o[i].data  = data_q[i];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      valid_q <= issue_i;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
      id_q[i]   <= op_i[i].dst_id;
      data_q[i] <= result[i];
    end
  end

endmodule

/* wired_backend.sv */
`timescale 1ns/100ps

module wired_backend #(
  parameter int unsigned ROB_DEPTH = 8
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             pkg_valid_i,
  output logic                             pkg_ready_o,
  input  logic [1:0]                       pkg_mask_i,
  input  wired_pipe_pkg::inst_pack_t [1:0] pkg_i,
  output wired_pipe_pkg::retire_t [1:0]    retire_o
);
  import wired_cfg_pkg::*;
  import wired_pipe_pkg::*;

  // wake up pending sources from either CDB lane
  function automatic dispatch_t cdb_capture(dispatch_t d, cdb_t [1:0] c);
    dispatch_t r;
    r = d;
    for (int s = 0; s < 2; s++) begin
      for (int l = 0; l < 2; l++) begin
        if (!d.src_rdy[s] && c[l].valid && c[l].id == d.src_id[s]) begin
          r.src_rdy[s] = 1'b1;
          r.src_val[s] = c[l].data;
        end
      end
    end
    return r;
  endfunction

  cdb_t [1:0]       cdb;
  logic             skid_busy_q;
  logic [1:0]       skid_mask_q;
  inst_pack_t [1:0] skid_pkg_q;
  inst_pack_t [1:0] r_pkg;
  logic [1:0]       r_mask;
  logic [1:0]       r_alloc;
  logic             r_valid;
  logic             r_ready;
  logic             room;
  arch_rid_t [3:0]  r_rs;
  arch_rid_t [1:0]  r_rd;
  data_t [3:0]      arf_rdata;
  logic [3:0]       ren_busy;
  rob_rid_t [3:0]   ren_id;
  logic [3:0]       look_done;
  data_t [3:0]      look_data;
  rob_rid_t [1:0]   alloc_id;
  logic [1:0]       rob_free;
  logic [1:0]       arf_we;
  arch_rid_t [1:0]  arf_waddr;
  data_t [1:0]      arf_wdata;
  rob_rid_t [1:0]   retire_id;
  dispatch_t [1:0]  r_disp;
  logic [1:0]       d_valid_q;
  dispatch_t [1:0]  d_op_q;
  dispatch_t [1:0]  d_op;
  logic [1:0]       d_issue;
  logic             d_leave;

  // skid buffer in front of rename
  assign pkg_ready_o = !skid_busy_q;
  assign r_valid     = pkg_valid_i || skid_busy_q;
  assign r_pkg       = skid_busy_q ? skid_pkg_q : pkg_i;
  assign r_mask      = {2{r_valid}} & (skid_busy_q ? skid_mask_q : pkg_mask_i);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      skid_busy_q <= 1'b0;
    end else begin
      skid_busy_q <= r_valid && !r_ready;
    end
  end

  always_ff @(posedge clk) begin
    if (!skid_busy_q) begin
      skid_mask_q <= pkg_mask_i;
      skid_pkg_q  <= pkg_i;
    end
  end

  // rob room for the valid slots, dispatch register free or leaving
  assign room    = (r_mask == 2'b11) ? rob_free[1] : (r_mask == 2'b00 || rob_free[0]);
  assign r_ready = room && d_leave;
  assign r_alloc = r_mask & {2{r_ready}};

  for (genvar i = 0; i < 2; i++) begin : g_slot
    assign r_rs[2*i]   = r_pkg[i].rs1;
    assign r_rs[2*i+1] = r_pkg[i].rs2;
    assign r_rd[i]     = r_pkg[i].rd;

    always_comb begin
      dispatch_t d;
      d        = '0;
      d.op     = r_pkg[i].op;
      d.imm    = r_pkg[i].imm;
      d.rd     = r_pkg[i].rd;
      d.dst_id = alloc_id[i];
      for (int s = 0; s < 2; s++) begin
        d.src_rdy[s] = !ren_busy[2*i+s] || look_done[2*i+s];
        d.src_id[s]  = ren_id[2*i+s];
        d.src_val[s] = ren_busy[2*i+s] ? look_data[2*i+s] : arf_rdata[2*i+s];
      end
      // a result on the bus right now would be missed otherwise
      r_disp[i] = cdb_capture(d, cdb);
    end

    assign d_op[i]    = cdb_capture(d_op_q[i], cdb);
    assign d_issue[i] = d_valid_q[i] && (&d_op[i].src_rdy);
  end

  assign d_leave = (d_valid_q & ~d_issue) == 2'b00;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      d_valid_q <= '0;
    end else if (r_valid && r_ready) begin
      d_valid_q <= r_alloc;
    end else begin
      d_valid_q <= d_valid_q & ~d_issue;
    end
  end

  always_ff @(posedge clk) begin
    d_op_q <= (r_valid && r_ready) ? r_disp : d_op;
  end

  wired_arf wired_arf_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .raddr_i (r_rs),
    .rdata_o (arf_rdata),
    .we_i    (arf_we),
    .waddr_i (arf_waddr),
    .wdata_i (arf_wdata)
  );

  wired_rename #(
    .ROB_DEPTH (ROB_DEPTH)
  ) wired_rename_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .rs_i        (r_rs),
    .alloc_i     (r_alloc),
    .rd_i        (r_rd),
    .alloc_id_i  (alloc_id),
    .busy_o      (ren_busy),
    .src_id_o    (ren_id),
    .retire_i    (arf_we),
    .retire_rd_i (arf_waddr),
    .retire_id_i (retire_id)
  );

  wired_rob #(
    .ROB_DEPTH (ROB_DEPTH)
  ) wired_rob_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .alloc_i     (r_alloc),
    .alloc_rd_i  (r_rd),
    .alloc_id_o  (alloc_id),
    .free_o      (rob_free),
    .cdb_i       (cdb),
    .look_id_i   (ren_id),
    .look_done_o (look_done),
    .look_data_o (look_data),
    .arf_we_o    (arf_we),
    .arf_waddr_o (arf_waddr),
    .arf_wdata_o (arf_wdata),
    .retire_id_o (retire_id),
    .retire_o    (retire_o)
  );

  wired_alu wired_alu_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .issue_i (d_issue),
    .op_i    (d_op),
    .cdb_o   (cdb)
  );

endmodule

/* tb_backend_asserts.sv */
`timescale 1ns/100ps

module tb_backend_asserts (
  input logic                             clk,
  input logic                             rst_n,
  input logic                             pkg_ready_i,
  input logic                             skid_busy_i,
  input logic [1:0]                       ren_mask_i,
  input wired_pipe_pkg::inst_pack_t [1:0] ren_pkg_i,
  input wired_pipe_pkg::cdb_t [1:0]       cdb_i,
  input wired_pipe_pkg::retire_t [1:0]    retire_i
);

  // older slot always retires first
  slot_order: assert property (@(posedge clk) disable iff (!rst_n)
    retire_i[1].valid |-> retire_i[0].valid)
    else $error("retire slot 1 valid without slot 0");

  ready_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> pkg_ready_i)
    else $error("pkg_ready_o low in the first cycle after reset");

  // held packet stays at rename while a new one waits at the input
  skid_full_blocks: assert property (@(posedge clk) disable iff (!rst_n)
    (skid_busy_i && $past(skid_busy_i)) |-> ($stable(ren_pkg_i) && $stable(ren_mask_i)))
    else $error("skid buffer accepted a packet while full");

  // first reset edge still sees the power-up value
  cdb_quiet_in_reset: assert property (@(posedge clk)
    (!rst_n && $past(!rst_n)) |-> (!cdb_i[0].valid && !cdb_i[1].valid))
    else $error("cdb valid during reset");

endmodule

bind wired_backend tb_backend_asserts asserts_inst (
  .clk         (clk),
  .rst_n       (rst_n),
  .pkg_ready_i (pkg_ready_o),
  .skid_busy_i (skid_busy_q),
  .ren_mask_i  (r_mask),
  .ren_pkg_i   (r_pkg),
  .cdb_i       (cdb),
  .retire_i    (retire_o)
);

/* tb_backend.sv */
`timescale 1ns/100ps

module tb_backend;
  import wired_cfg_pkg::*;
  import wired_pipe_pkg::*;

  localparam int unsigned WAIT_LIMIT = 200;

  logic             clk = 1'b0;
  logic             rst_n;
  logic             pkg_valid_i;
  logic             pkg_ready_o;
  logic [1:0]       pkg_mask_i;
  inst_pack_t [1:0] pkg_i;
  retire_t [1:0]    retire_o;

  logic [15:0] lfsr;
  data_t       model_regs [NREG];
  retire_t     expect_q [$];
  int unsigned pushed_cnt = 0;
  int unsigned retired_cnt = 0;

  wired_backend #(
    .ROB_DEPTH (8)
  ) wired_backend_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .pkg_valid_i (pkg_valid_i),
    .pkg_ready_o (pkg_ready_o),
    .pkg_mask_i  (pkg_mask_i),
    .pkg_i       (pkg_i),
    .retire_o    (retire_o)
  );

  always #5 clk = ~clk;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [15:0] rand_bits(input int unsigned n);
    logic [15:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[14:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic data_t alu_ref(input alu_op_t op, input data_t a, input data_t b,
                                    input logic [15:0] imm);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_LI:   return data_t'(signed'(imm));
      default: return '0;
    endcase
  endfunction

  // program-order execution of one accepted packet
  function automatic void model_packet(input logic [1:0] mask, input inst_pack_t [1:0] p);
    retire_t rec;
    for (int s = 0; s < 2; s++) begin
      if (mask[s]) begin
        rec.valid = 1'b1;
        rec.rd    = p[s].rd;
        rec.data  = alu_ref(p[s].op, model_regs[p[s].rs1], model_regs[p[s].rs2], p[s].imm);
        if (p[s].rd == '0) begin
          rec.data = '0;
        end else begin
          model_regs[p[s].rd] = rec.data;
        end
        expect_q.push_back(rec);
        pushed_cnt++;
      end
    end
  endfunction

  function automatic inst_pack_t make_inst(input alu_op_t op, input arch_rid_t rd,
                                           input arch_rid_t rs1, input arch_rid_t rs2,
                                           input logic [15:0] imm);
    inst_pack_t i;
    i.op  = op;
    i.rd  = rd;
    i.rs1 = rs1;
    i.rs2 = rs2;
    i.imm = imm;
    return i;
  endfunction

  // registers x0..x7 only, so dependencies are frequent
  function automatic inst_pack_t rand_inst();
    inst_pack_t i;
    i.op  = alu_op_t'(rand_bits(3) % 6);
    i.rd  = arch_rid_t'(rand_bits(3));
    i.rs1 = arch_rid_t'(rand_bits(3));
    i.rs2 = arch_rid_t'(rand_bits(3));
    i.imm = rand_bits(16);
    return i;
  endfunction

  task automatic abort_run();
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, want);
      abort_run();
    end
  endtask

  task automatic idle_cycles(input int unsigned n);
    repeat (n) @(negedge clk);
  endtask

  // hold the packet until the backend takes it
  task automatic send_packet(input logic [1:0] mask, input inst_pack_t i0,
                             input inst_pack_t i1);
    int unsigned waited;
    waited      = 0;
    pkg_valid_i = 1'b1;
    pkg_mask_i  = mask;
    pkg_i[0]    = i0;
    pkg_i[1]    = i1;
    while (pkg_ready_o !== 1'b1) begin
      if (waited == WAIT_LIMIT) begin
        $display("pkg_ready_o stayed low for %0d cycles", WAIT_LIMIT);
        abort_run();
      end
      @(negedge clk);
      waited++;
    end
    model_packet(mask, pkg_i);
    @(negedge clk);
    pkg_valid_i = 1'b0;
  endtask

  task automatic wait_drained();
    int unsigned waited;
    waited = 0;
    while (expect_q.size() != 0) begin
      if (waited == WAIT_LIMIT) begin
        $display("%0d retires still missing after %0d cycles", expect_q.size(), WAIT_LIMIT);
        abort_run();
      end
      @(posedge clk);
      waited++;
    end
    @(negedge clk);
  endtask

  // retire_o is registered, stable at the falling edge
  always @(negedge clk) begin
    retire_t want;
    for (int s = 0; s < 2; s++) begin
      if (retire_o[s].valid === 1'b1) begin
        if (expect_q.size() == 0) begin
          $display("retire slot %0d fired with no instruction outstanding", s);
          abort_run();
        end else begin
          want = expect_q.pop_front();
          check_value("retire_o.rd", 32'(retire_o[s].rd), 32'(want.rd));
          check_value("retire_o.data", retire_o[s].data, want.data);
          retired_cnt++;
        end
      end
    end
  end

  initial begin
    rst_n       = 1'b0;
    pkg_valid_i = 1'b0;
    pkg_mask_i  = 2'b00;
    pkg_i       = '0;
    lfsr        = 16'd51147;
    for (int r = 0; r < NREG; r++) begin
      model_regs[r] = '0;
    end
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    // nothing may retire before the first packet
    idle_cycles(6);
    check_value("pkg_ready_o", 32'(pkg_ready_o), 32'd1);

    send_packet(2'b11, make_inst(OP_LI, 5'd1, 5'd0, 5'd0, 16'h0005),
                make_inst(OP_LI, 5'd2, 5'd0, 5'd0, 16'hfffd));
    idle_cycles(6);
    send_packet(2'b11, make_inst(OP_ADD, 5'd3, 5'd1, 5'd2, 16'h0000),
                make_inst(OP_XOR, 5'd4, 5'd1, 5'd2, 16'h0000));
    idle_cycles(2);
    // slot 1 uses slot 0's result
    send_packet(2'b11, make_inst(OP_LI, 5'd5, 5'd0, 5'd0, 16'h1234),
                make_inst(OP_ADD, 5'd6, 5'd5, 5'd1, 16'h0000));

    // chains across back-to-back packets
    for (int n = 0; n < 6; n++) begin
      send_packet(2'b11, make_inst(OP_ADD, 5'd7, 5'd7, 5'd1, 16'h0000),
                  make_inst(OP_SUB, 5'd8, 5'd7, 5'd2, 16'h0000));
    end
    send_packet(2'b11, make_inst(OP_OR, 5'd9, 5'd8, 5'd3, 16'h0000),
                make_inst(OP_XOR, 5'd7, 5'd7, 5'd9, 16'h0000));

    // masked slots and x0 writes
    send_packet(2'b01, make_inst(OP_LI, 5'd10, 5'd0, 5'd0, 16'h0a0a),
                make_inst(OP_LI, 5'd11, 5'd0, 5'd0, 16'h7777));
    send_packet(2'b10, make_inst(OP_LI, 5'd10, 5'd0, 5'd0, 16'h5555),
                make_inst(OP_LI, 5'd11, 5'd0, 5'd0, 16'h0b0b));
    send_packet(2'b11, make_inst(OP_LI, 5'd0, 5'd0, 5'd0, 16'h0055),
                make_inst(OP_ADD, 5'd12, 5'd0, 5'd11, 16'h0000));
    send_packet(2'b11, make_inst(OP_ADD, 5'd13, 5'd0, 5'd10, 16'h0000),
                make_inst(OP_OR, 5'd14, 5'd10, 5'd11, 16'h0000));
    wait_drained();

    // long dependent chain, then random traffic with gaps
    for (int n = 0; n < 40; n++) begin
      send_packet(2'b11, make_inst(OP_ADD, 5'd7, 5'd7, 5'd1, 16'h0000),
                  make_inst(OP_ADD, 5'd7, 5'd7, 5'd7, 16'h0000));
    end
    for (int n = 0; n < 300; n++) begin
      send_packet(2'(rand_bits(2)), rand_inst(), rand_inst());
      if (rand_bits(2) == 16'd0) begin
        idle_cycles(rand_bits(2));
      end
    end
    wait_drained();

    // extra retires would show up here
    idle_cycles(10);
    if (retired_cnt == pushed_cnt && expect_q.size() == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("retired %0d instructions but expected %0d", retired_cnt, pushed_cnt);
      abort_run();
    end
  end

endmodule

/* flist.f */
wired_cfg_pkg.sv
wired_pipe_pkg.sv
wired_arf.sv
wired_rename.sv
wired_rob.sv
wired_alu.sv
wired_backend.sv
tb_backend_asserts.sv
tb_backend.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run tb_backend with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1

log_file="sim.log"
obj_dir="obj_dir"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_backend -Mdir "$obj_dir" -f flist.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$obj_dir/Vtb_backend" > "$log_file" 2>&1
status=$?
cat "$log_file"

if grep -q "TEST FAIL" "$log_file"; then
  echo "simulation reported a failure, see $log_file"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
if ! grep -q "TEST PASS" "$log_file"; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
exit 0
